// File: design/atCalc.sv
`timescale 1ns/10ps

module atCalc (
	input  hazardPkg::instrWord_u  instr,
	input  hazardPkg::instrClass_e cls,
	output hazardPkg::atInfo_s     at
);
	import hazardPkg::*;

	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;

	assign rs = instr.iFields.rs;
	assign rt = instr.iFields.rt;
	assign rd = instr.rFields.rd; // Only present in the R view

	//////////////////////////////////////////////////////////////////////
	// Tuse/Tnew table, one row per class
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		// Unused ports read r0 and never need a value
		at.rAddr0 = 5'd0;
		at.rAddr1 = 5'd0;
		at.wAddr  = 5'd0;
		at.tuse0  = TUSE_NONE;
		at.tuse1  = TUSE_NONE;
		at.tnew   = 3'd0;
		case (cls)
			CLS_ALUR:
			begin
				at.rAddr0 = rs;
				at.rAddr1 = rt;
				at.wAddr  = rd;
				at.tuse0  = 3'd1;
				at.tuse1  = 3'd1;
				at.tnew   = 3'd2; // Result at end of EX
			end
			CLS_ALUI:
			begin
				at.rAddr0 = rs;
				at.wAddr  = rt;
				at.tuse0  = 3'd1;
				at.tnew   = 3'd2;
			end
			CLS_LOAD:
			begin
				at.rAddr0 = rs;   // Base address in EX
				at.wAddr  = rt;
				at.tuse0  = 3'd1;
				at.tnew   = 3'd3; // Data out of MEM
			end
			CLS_STORE:
			begin
				at.rAddr0 = rs;
				at.rAddr1 = rt;
				at.tuse0  = 3'd1;
				at.tuse1  = 3'd2; // Store data not needed until MEM
			end
			CLS_BRANCH:
			begin
				at.rAddr0 = rs; // Compared in ID
				at.rAddr1 = rt;
				at.tuse0  = 3'd0;
				at.tuse1  = 3'd0;
			end
			CLS_LUI:
			begin
				at.wAddr = rt;
				at.tnew  = 3'd1; // Value known in ID
			end
			CLS_JAL:
			begin
				at.wAddr = REG_RA;
				at.tnew  = 3'd1; // Link address known in ID
			end
			CLS_JR:
			begin
				at.rAddr0 = rs;
				at.tuse0  = 3'd0; // Target needed right away
			end
			CLS_JALR:
			begin
				at.rAddr0 = rs;
				at.wAddr  = rd;
				at.tuse0  = 3'd0;
				at.tnew   = 3'd1;
			end
			default: ; // j and nop keep the defaults
		endcase
	end

endmodule

// File: design/hazardCtrl.sv
`timescale 1ns/10ps

module hazardCtrl (
	input  logic                   instrValid,
	input  hazardPkg::atInfo_s     at,
	input  hazardPkg::stageEntry_s exE,
	input  hazardPkg::stageEntry_s memE,
	input  hazardPkg::stageEntry_s wbE,
	output logic                   stall,
	output logic                   issue,
	output hazardPkg::fwdSel_e     fwdRs,
	output hazardPkg::fwdSel_e     fwdRt
);
	import hazardPkg::*;

	logic hazRs; // rs side waits on some stage
	logic hazRt;
	fwdSel_e srcRs; // Match before stall masking
	fwdSel_e srcRt;

	// Value needed before the writer in e can produce it
	function automatic logic isHazard(input logic [4:0] addr, input logic [2:0] tuse,
			input stageEntry_s e);
		return (addr != 5'd0) && (addr == e.wAddr) && (tuse < e.tnew);
	endfunction

	// Youngest matching writer wins
	function automatic fwdSel_e pickSource(input logic [4:0] addr, input stageEntry_s ex,
			input stageEntry_s mem, input stageEntry_s wb);
		fwdSel_e sel;
		sel = FWD_NONE;
		if (addr != 5'd0)
		begin
			if (addr == ex.wAddr)
				sel = FWD_EX;
			else if (addr == mem.wAddr)
				sel = FWD_MEM;
			else if (addr == wb.wAddr)
				sel = FWD_WB;
		end
		return sel;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stall decision and forward selects
	//////////////////////////////////////////////////////////////////////

	assign hazRs = isHazard(at.rAddr0, at.tuse0, exE) ||
		isHazard(at.rAddr0, at.tuse0, memE) ||
		isHazard(at.rAddr0, at.tuse0, wbE);
	assign hazRt = isHazard(at.rAddr1, at.tuse1, exE) ||
		isHazard(at.rAddr1, at.tuse1, memE) ||
		isHazard(at.rAddr1, at.tuse1, wbE);

	assign stall = instrValid && (hazRs || hazRt);
	assign issue = instrValid && !stall; // Tracker only sees real issues

	assign srcRs = pickSource(at.rAddr0, exE, memE, wbE);
	assign srcRt = pickSource(at.rAddr1, exE, memE, wbE);

	// No forwarding while the instruction is held
	assign fwdRs = stall ? FWD_NONE : srcRs;
	assign fwdRt = stall ? FWD_NONE : srcRt;

endmodule

// File: design/hazardPkg.sv
package hazardPkg;

	//////////////////////////////////////////////////////////////////////
	// Opcode and funct encodings of the supported MIPS subset
	//////////////////////////////////////////////////////////////////////

	localparam logic [5:0] OP_SPECIAL = 6'h00; // R-type, decoded further by funct
	localparam logic [5:0] OP_J       = 6'h02;
	localparam logic [5:0] OP_JAL     = 6'h03;
	localparam logic [5:0] OP_BEQ     = 6'h04;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_LUI     = 6'h0f;
	localparam logic [5:0] OP_LW      = 6'h23;
	localparam logic [5:0] OP_SW      = 6'h2b;

	// SPECIAL funct codes
	localparam logic [5:0] FN_SLL  = 6'h00; // All-zero word lands here
	localparam logic [5:0] FN_JR   = 6'h08;
	localparam logic [5:0] FN_JALR = 6'h09;
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;

	// Use time for a port the instruction never reads
	// Larger than any Tnew, so such a port can never be hazardous
	localparam logic [2:0] TUSE_NONE = 3'd7;

	localparam logic [4:0] REG_RA = 5'd31; // Link register of jal

	//////////////////////////////////////////////////////////////////////
	// Instruction word, two views of the same 32 bits
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFields_s;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16; // Unused by the hazard logic
	} iFields_s;

	typedef union packed {
		rFields_s rFields; // Register format
		iFields_s iFields; // Immediate format
	} instrWord_u;

	// Instruction class seen by the Tuse/Tnew table
	typedef enum logic [3:0] {
		CLS_NOP,
		CLS_ALUR,   // addu, subu, sll
		CLS_ALUI,   // ori, addiu
		CLS_LOAD,   // lw
		CLS_STORE,  // sw
		CLS_BRANCH, // beq
		CLS_LUI,
		CLS_JAL,
		CLS_JR,
		CLS_J,
		CLS_JALR
	} instrClass_e;

	//////////////////////////////////////////////////////////////////////
	// Hazard bookkeeping
	//////////////////////////////////////////////////////////////////////

	// Read and write view of the ID instruction
	typedef struct packed {
		logic [4:0] rAddr0; // rs side
		logic [4:0] rAddr1; // rt side
		logic [4:0] wAddr;  // 0 when nothing is written
		logic [2:0] tuse0;  // Cycles from ID until rAddr0 is needed
		logic [2:0] tuse1;
		logic [2:0] tnew;   // Cycles from ID until wAddr value exists
	} atInfo_s;

	// Writer held in one later stage, tnew counts what is left
	typedef struct packed {
		logic [4:0] wAddr;
		logic [2:0] tnew;
	} stageEntry_s;

	localparam stageEntry_s STAGE_BUBBLE = '{wAddr: 5'd0, tnew: 3'd0};

	// Source picked for a read port, in priority order
	typedef enum logic [1:0] {
		FWD_NONE,
		FWD_EX,
		FWD_MEM,
		FWD_WB
	} fwdSel_e;

endpackage

// File: design/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit (
	input  logic                  clk,
	input  logic                  arstN,
	input  hazardPkg::instrWord_u instr,      // ID stage word
	input  logic                  instrValid,
	output logic                  stall,      // Hold IF/ID, bubble into EX
	output hazardPkg::fwdSel_e    fwdRs,
	output hazardPkg::fwdSel_e    fwdRt
);
	import hazardPkg::*;

	instrClass_e cls;
	atInfo_s     at;
	stageEntry_s exE;
	stageEntry_s memE;
	stageEntry_s wbE;
	logic        issue;

	//////////////////////////////////////////////////////////////////////
	// ID side, all combinational
	//////////////////////////////////////////////////////////////////////

	instrDecoder decoder_i (
		.instr (instr),
		.cls   (cls)
	);

	atCalc calc_i (
		.instr (instr),
		.cls   (cls),
		.at    (at)
	);

	hazardCtrl ctrl_i (
		.instrValid (instrValid),
		.at         (at),
		.exE        (exE),
		.memE       (memE),
		.wbE        (wbE),
		.stall      (stall),
		.issue      (issue),
		.fwdRs      (fwdRs),
		.fwdRt      (fwdRt)
	);

	// Writers in flight behind ID
	stageTracker tracker_i (
		.clk   (clk),
		.arstN (arstN),
		.issue (issue),
		.at    (at),
		.exE   (exE),
		.memE  (memE),
		.wbE   (wbE)
	);

endmodule

// File: design/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder (
	input  hazardPkg::instrWord_u  instr,
	output hazardPkg::instrClass_e cls
);
	import hazardPkg::*;

	logic [5:0] opcode; // From the I view, same bits in both
	logic [5:0] funct;  // Only meaningful for SPECIAL

	assign opcode = instr.iFields.opcode;
	assign funct  = instr.rFields.funct;

	//////////////////////////////////////////////////////////////////////
	// Opcode first, funct only under SPECIAL
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		cls = CLS_NOP; // Anything unknown falls out as a nop
		case (opcode)
			OP_SPECIAL:
			begin
				case (funct)
					FN_ADDU,
					FN_SUBU,
					FN_SLL:  cls = CLS_ALUR; // sll $0 covers the zero word
					FN_JR:   cls = CLS_JR;
					FN_JALR: cls = CLS_JALR;
					default: cls = CLS_NOP;
				endcase
			end
			OP_ORI,
			OP_ADDIU: cls = CLS_ALUI;
			OP_LW:    cls = CLS_LOAD;
			OP_SW:    cls = CLS_STORE;
			OP_BEQ:   cls = CLS_BRANCH;
			OP_LUI:   cls = CLS_LUI;
			OP_JAL:   cls = CLS_JAL;
			OP_J:     cls = CLS_J;
			default:  cls = CLS_NOP;
		endcase
	end

endmodule

// File: design/stageTracker.sv
`timescale 1ns/10ps

module stageTracker (
	input  logic                   clk,
	input  logic                   arstN,
	input  logic                   issue,
	input  hazardPkg::atInfo_s     at,
	output hazardPkg::stageEntry_s exE,
	output hazardPkg::stageEntry_s memE,
	output hazardPkg::stageEntry_s wbE
);
	import hazardPkg::*;

	stageEntry_s idEntry; // Writer of the ID instruction
	stageEntry_s nxtEx;   // What EX takes at the next edge

	// One stage further on, count saturates at 0
	function automatic stageEntry_s ageEntry(input stageEntry_s e);
		stageEntry_s aged;
		aged.wAddr = e.wAddr;
		aged.tnew  = (e.tnew == 3'd0) ? 3'd0 : e.tnew - 3'd1;
		return aged;
	endfunction

	assign idEntry = '{wAddr: at.wAddr, tnew: at.tnew};

	// A held instruction leaves a bubble behind it
	assign nxtEx = issue ? ageEntry(idEntry) : STAGE_BUBBLE;

	//////////////////////////////////////////////////////////////////////
	// EX, MEM, WB writer shift
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			exE  <= STAGE_BUBBLE; // Empty pipe, nothing to wait on
			memE <= STAGE_BUBBLE;
			wbE  <= STAGE_BUBBLE;
		end
		else
		begin
			exE  <= nxtEx;
			memE <= ageEntry(exE);
			wbE  <= ageEntry(memE); // Leaves the tracker after WB
		end
	end

endmodule

// File: run.sh
#!/bin/sh
# Build and run the hazard unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module hazardUnitTb -f src.f

out=$(./obj_dir/VhazardUnitTb)
echo "$out"

# Fails the script unless the pass line is present
echo "$out" | grep -q "^Result: PASSED$"
echo "Simulation passed"

// File: sim/hazardModel.svh
`ifndef HAZARD_MODEL_SVH
`define HAZARD_MODEL_SVH

logic [31:0] lfsrState; // Fibonacci LFSR, taps 32 22 2 1

// One LFSR step for every bit handed out
function automatic logic [31:0] takeBits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
	begin
		lfsrState = {lfsrState[30:0], lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
		v = {v[30:0], lfsrState[0]};
	end
	return v;
endfunction

//////////////////////////////////////////////////////////////////////
// Instruction builders
//////////////////////////////////////////////////////////////////////

function automatic instrWord_u rType(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [5:0] fn);
	return {OP_SPECIAL, rs, rt, rd, 5'd0, fn}; // shamt kept 0
endfunction

function automatic instrWord_u iType(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

//////////////////////////////////////////////////////////////////////
// Reference rules
//////////////////////////////////////////////////////////////////////

// Reads, write and timing per instruction, field order of atInfo_s
function automatic atInfo_s refInfo(input instrWord_u w);
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	atInfo_s r;
	rs = w.rFields.rs;
	rt = w.rFields.rt;
	rd = w.rFields.rd;
	r = {5'd0, 5'd0, 5'd0, TUSE_NONE, TUSE_NONE, 3'd0}; // Nop row
	case (w.rFields.opcode)
		OP_SPECIAL:
		begin
			if (w.rFields.funct inside {FN_ADDU, FN_SUBU, FN_SLL})
				r = {rs, rt, rd, 3'd1, 3'd1, 3'd2};
			else if (w.rFields.funct == FN_JR)
				r = {rs, 5'd0, 5'd0, 3'd0, TUSE_NONE, 3'd0};
			else if (w.rFields.funct == FN_JALR)
				r = {rs, 5'd0, rd, 3'd0, TUSE_NONE, 3'd1};
		end
		OP_ORI, OP_ADDIU: r = {rs, 5'd0, rt, 3'd1, TUSE_NONE, 3'd2};
		OP_LW:   r = {rs, 5'd0, rt, 3'd1, TUSE_NONE, 3'd3};
		OP_SW:   r = {rs, rt, 5'd0, 3'd1, 3'd2, 3'd0};  // Store data late
		OP_BEQ:  r = {rs, rt, 5'd0, 3'd0, 3'd0, 3'd0};
		OP_LUI:  r = {5'd0, 5'd0, rt, TUSE_NONE, TUSE_NONE, 3'd1};
		OP_JAL:  r = {5'd0, 5'd0, REG_RA, TUSE_NONE, TUSE_NONE, 3'd1};
		default: ; // j and unknown words
	endcase
	return r;
endfunction

function automatic logic waitsOn(input logic [4:0] a, input logic [2:0] u,
		input stageEntry_s e);
	return (a != 5'd0) && (a == e.wAddr) && (u < e.tnew);
endfunction

// WB first so a younger match overrides it
function automatic fwdSel_e fwdFrom(input logic [4:0] a, input stageEntry_s ex,
		input stageEntry_s mem, input stageEntry_s wb);
	fwdSel_e sel;
	sel = FWD_NONE;
	if (a != 5'd0 && a == wb.wAddr)
		sel = FWD_WB;
	if (a != 5'd0 && a == mem.wAddr)
		sel = FWD_MEM;
	if (a != 5'd0 && a == ex.wAddr)
		sel = FWD_EX;
	return sel;
endfunction

function automatic stageEntry_s countDown(input stageEntry_s e);
	return {e.wAddr, (e.tnew > 3'd0) ? e.tnew - 3'd1 : 3'd0}; // Stops at 0
endfunction

`endif

// File: sim/hazardUnitTb.sv
`timescale 1ns/10ps

module hazardUnitTb;
	import hazardPkg::*;

	localparam int RESET_CYCLES  = 10;
	localparam int DIRECT_CYCLES = 120;
	localparam int RANDOM_COUNT  = 300;
	localparam int STALL_LIMIT   = 4;
	// Random instructions take at most three cycles each
	localparam int WATCHDOG_NS = (RESET_CYCLES + DIRECT_CYCLES + 3 * RANDOM_COUNT + 50) * 8;

	logic        clk;
	logic        arstN;
	instrWord_u  instr;
	logic        instrValid;
	logic        stall;
	fwdSel_e     fwdRs;
	fwdSel_e     fwdRt;

	int errCount;     // Directed checks
	int modelErrs;    // Model comparison
	int testCount;
	int testsFailing;

	stageEntry_s modEx; // Model copy of the writers in flight
	stageEntry_s modMem;
	stageEntry_s modWb;
	atInfo_s     expAt;
	logic        expStall;
	fwdSel_e     expRs;
	fwdSel_e     expRt;
	logic        hazRs;
	logic        hazRt;

	`include "hazardModel.svh"

	hazardUnit dut_i (
		.clk        (clk),
		.arstN      (arstN),
		.instr      (instr),
		.instrValid (instrValid),
		.stall      (stall),
		.fwdRs      (fwdRs),
		.fwdRt      (fwdRt)
	);

	always #4 clk = ~clk; // 8 ns period

	//////////////////////////////////////////////////////////////////////
	// Reference model and per-cycle comparison
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		expAt = refInfo(instr);
		hazRs = waitsOn(expAt.rAddr0, expAt.tuse0, modEx) ||
			waitsOn(expAt.rAddr0, expAt.tuse0, modMem) || waitsOn(expAt.rAddr0, expAt.tuse0, modWb);
		hazRt = waitsOn(expAt.rAddr1, expAt.tuse1, modEx) ||
			waitsOn(expAt.rAddr1, expAt.tuse1, modMem) || waitsOn(expAt.rAddr1, expAt.tuse1, modWb);
		expStall = instrValid && (hazRs || hazRt);
		expRs = expStall ? FWD_NONE : fwdFrom(expAt.rAddr0, modEx, modMem, modWb);
		expRt = expStall ? FWD_NONE : fwdFrom(expAt.rAddr1, modEx, modMem, modWb);
	end

	always @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			modEx  <= '0;
			modMem <= '0;
			modWb  <= '0;
		end
		else
		begin
			modEx  <= (instrValid && !expStall) ? countDown({expAt.wAddr, expAt.tnew}) : '0;
			modMem <= countDown(modEx);
			modWb  <= countDown(modMem);
		end
	end

	// Sampled mid-cycle, inputs move on the rising edge
	stallModel: assert property (@(negedge clk) disable iff (!arstN) stall == expStall)
	else
	begin
		$display("CHECK FAILED stall: exp 0x%0h got 0x%0h", expStall, stall);
		modelErrs++;
	end
	fwdRsModel: assert property (@(negedge clk) disable iff (!arstN) fwdRs == expRs)
	else
	begin
		$display("CHECK FAILED fwdRs: exp 0x%0h got 0x%0h", expRs, fwdRs);
		modelErrs++;
	end
	fwdRtModel: assert property (@(negedge clk) disable iff (!arstN) fwdRt == expRt)
	else
	begin
		$display("CHECK FAILED fwdRt: exp 0x%0h got 0x%0h", expRt, fwdRt);
		modelErrs++;
	end

	//////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	//////////////////////////////////////////////////////////////////////

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		valueCheck: assert (got == exp)
		else
		begin
			$display("CHECK FAILED %s: exp 0x%0h got 0x%0h", name, exp, got);
			errCount++;
		end
	endtask

	task automatic idleCycles(input int n);
		repeat (n)
		begin
			@(posedge clk);
			instrValid <= 1'b0;
			instr      <= '0;
		end
	endtask

	// Holds the word until the unit lets it go, counting stall cycles
	task automatic driveInstr(input instrWord_u w, input logic valid, output int stalls);
		stalls = 0;
		@(posedge clk);
		instr      <= w;
		instrValid <= valid;
		@(negedge clk);
		while (stall && stalls < STALL_LIMIT)
		begin
			stalls++;
			@(negedge clk);
		end
		if (stall)
		begin
			$display("Stall did not clear within %0d cycles for word 0x%08h", STALL_LIMIT, w);
			errCount++;
		end
	endtask

	task automatic sendInstr(input instrWord_u w, input int expStalls, input fwdSel_e expSrcRs,
			input fwdSel_e expSrcRt);
		int stalls;
		driveInstr(w, 1'b1, stalls);
		checkValue("stall cycles", stalls, expStalls);
		checkValue("fwdRs", 32'(fwdRs), 32'(expSrcRs)); // Issue cycle
		checkValue("fwdRt", 32'(fwdRt), 32'(expSrcRt));
	endtask

	task automatic randomStream(input int count);
		logic [31:0] bits;
		logic [4:0]  ra;
		logic [4:0]  rb;
		logic [4:0]  rc;
		instrWord_u  w;
		int          stalls;
		for (int n = 0; n < count; n++)
		begin
			bits = takeBits(16);
			ra = {2'b00, bits[6:4]}; // Few registers, many collisions
			rb = {2'b00, bits[9:7]};
			rc = {2'b00, bits[12:10]};
			case (bits[3:0])
				4'd0:    w = rType(ra, rb, rc, FN_ADDU);
				4'd1:    w = rType(ra, rb, rc, FN_SUBU);
				4'd2:    w = rType(5'd0, rb, rc, FN_SLL);
				4'd3:    w = iType(OP_ORI, ra, rb, 16'h00ff);
				4'd4:    w = iType(OP_ADDIU, ra, rb, 16'h0004);
				4'd5:    w = iType(OP_LW, ra, rb, 16'h0010);
				4'd6:    w = iType(OP_SW, ra, rb, 16'h0010);
				4'd7:    w = iType(OP_BEQ, ra, rb, 16'h0003);
				4'd8:    w = iType(OP_LUI, 5'd0, rb, 16'h1234);
				4'd9:    w = iType(OP_JAL, ra, rb, 16'h0040);
				4'd10:   w = rType(bits[10] ? REG_RA : ra, 5'd0, 5'd0, FN_JR);
				4'd11:   w = iType(OP_J, ra, rb, 16'h0040);
				4'd12:   w = rType(ra, 5'd0, rc, FN_JALR);
				4'd13:   w = iType(6'h3f, ra, rb, 16'h0000); // Unknown opcode
				4'd14:   w = rType(ra, rb, rc, 6'h3f);      // Unknown funct
				default: w = '0;
			endcase
			driveInstr(w, bits[15:13] != 3'd0, stalls);
		end
	endtask

	task automatic endTest(input string name, input int errsBefore);
		testCount++;
		if (errCount + modelErrs == errsBefore)
			$display("Test %0d %s: ok", testCount, name);
		else
		begin
			testsFailing++;
			$display("Test %0d %s: %0d errors", testCount, name, errCount + modelErrs - errsBefore);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int errsBefore;
		clk        = 1'b0;
		arstN      = 1'b0;
		instr      = '0;
		instrValid = 1'b0;
		lfsrState  = 32'h267f;
		errCount   = 0;
		modelErrs  = 0;
		repeat (RESET_CYCLES) @(posedge clk);
		arstN <= 1'b1;
		instr <= rType(5'd1, 5'd2, 5'd3, FN_ADDU); // Reads r1 and r2, never issued

		// Entries still hold their reset values here
		errsBefore = 0;
		@(negedge clk);
		checkValue("stall", 32'(stall), 32'd0);
		checkValue("fwdRs", 32'(fwdRs), 32'(FWD_NONE));
		checkValue("fwdRt", 32'(fwdRt), 32'(FWD_NONE));
		endTest("idle after reset", errsBefore);

		errsBefore = errCount + modelErrs;
		idleCycles(4);
		sendInstr(rType(5'd1, 5'd2, 5'd5, FN_ADDU), 0, FWD_NONE, FWD_NONE);
		sendInstr(rType(5'd5, 5'd0, 5'd6, FN_ADDU), 0, FWD_EX, FWD_NONE);
		sendInstr(rType(5'd3, 5'd5, 5'd7, FN_ADDU), 0, FWD_NONE, FWD_MEM);
		endTest("alu to alu forwarding", errsBefore);

		errsBefore = errCount + modelErrs;
		idleCycles(4);
		sendInstr(iType(OP_LW, 5'd1, 5'd8, 16'h0004), 0, FWD_NONE, FWD_NONE);
		sendInstr(rType(5'd8, 5'd2, 5'd9, FN_ADDU), 1, FWD_MEM, FWD_NONE);
		idleCycles(4);
		sendInstr(iType(OP_LW, 5'd1, 5'd8, 16'h0004), 0, FWD_NONE, FWD_NONE);
		sendInstr(iType(OP_BEQ, 5'd8, 5'd0, 16'h0002), 2, FWD_WB, FWD_NONE);
		endTest("load use stalls", errsBefore);

		errsBefore = errCount + modelErrs;
		idleCycles(4);
		sendInstr(rType(5'd1, 5'd2, 5'd10, FN_ADDU), 0, FWD_NONE, FWD_NONE);
		sendInstr(iType(OP_SW, 5'd3, 5'd10, 16'h0008), 0, FWD_NONE, FWD_EX);
		sendInstr(iType(OP_JAL, 5'd0, 5'd0, 16'h0010), 0, FWD_NONE, FWD_NONE);
		sendInstr(rType(REG_RA, 5'd0, 5'd0, FN_JR), 0, FWD_EX, FWD_NONE);
		endTest("store data and jal link", errsBefore);

		errsBefore = errCount + modelErrs;
		idleCycles(4);
		sendInstr(rType(5'd1, 5'd2, 5'd0, FN_ADDU), 0, FWD_NONE, FWD_NONE);
		sendInstr(rType(5'd0, 5'd0, 5'd4, FN_ADDU), 0, FWD_NONE, FWD_NONE);
		sendInstr(iType(OP_LW, 5'd1, 5'd0, 16'h0000), 0, FWD_NONE, FWD_NONE);
		sendInstr(iType(OP_BEQ, 5'd0, 5'd0, 16'h0001), 0, FWD_NONE, FWD_NONE);
		sendInstr(iType(OP_LW, 5'd1, 5'd8, 16'h0000), 0, FWD_NONE, FWD_NONE);
		sendInstr(iType(6'h3f, 5'd8, 5'd11, 16'h0000), 0, FWD_NONE, FWD_NONE);
		sendInstr(rType(5'd8, 5'd8, 5'd11, 6'h3f), 0, FWD_NONE, FWD_NONE);
		sendInstr(rType(5'd11, 5'd0, 5'd12, FN_ADDU), 0, FWD_NONE, FWD_NONE);
		endTest("r0 and unknown encodings", errsBefore);

		errsBefore = errCount + modelErrs;
		idleCycles(4);
		randomStream(RANDOM_COUNT);
		idleCycles(4);
		endTest("random stream", errsBefore);

		$display("Tests run %0d, failing %0d, check errors %0d", testCount, testsFailing,
			errCount + modelErrs);
		if (errCount + modelErrs == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

	// Run length bound
	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// File: src.f
+incdir+sim
design/hazardPkg.sv
design/instrDecoder.sv
design/atCalc.sv
design/stageTracker.sv
design/hazardCtrl.sv
design/hazardUnit.sv
sim/hazardUnitTb.sv
